// File: tb.f
+incdir+common
+incdir+bench
common/regex_pkg.sv
design/text_fetcher/text_fetcher.sv
design/pattern_lane.sv
design/match_verdict.sv
design/regex_coprocessor.sv
bench/regex_assertions.sv
bench/tb_regex_coprocessor.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the coprocessor testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_regex_coprocessor -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -qx "Simulation finished: PASS" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }

// File: bench/tb_regex_tests.svh
// test tasks use the bench top's signals; pattern strings use '.' for the dot symbol
task automatic load_string(input int addr, input string text);
    for (int i = 0; i < text.len(); i++)
        mem_bytes[addr + i] = text[i];
endtask

task automatic encode_pattern(input string pat, output pat_chars_t chars,
                              output pat_any_t any, output pat_len_t len);
    chars = '0;
    any   = '0;
    len   = pat_len_t'(pat.len());
    for (int i = 0; i < pat.len(); i++)
    begin
        chars[i*`REGEX_CHAR_W +: `REGEX_CHAR_W] = pat[i];
        any[i] = (pat[i] == ".");
    end
endtask

// reference model: anchored prefix match, empty pattern never matches
function automatic logic prefix_matches(input string text, input string pat);
    if (pat.len() == 0 || text.len() < pat.len())
        return 1'b0;
    for (int i = 0; i < pat.len(); i++)
        if (pat[i] != "." && pat[i] != text[i])
            return 1'b0;
    return 1'b1;
endfunction

function automatic logic model_accept(input string text, input string pat_a, input string pat_b);
    return prefix_matches(text, pat_a) || prefix_matches(text, pat_b);
endfunction

// hold valid until the handshake, then wait for done and count it
task automatic run_job(input string test_name, input text_ptr_t first, input text_ptr_t last,
                       input string pat_a, input string pat_b, output logic got_accept);
    step_cycle();
    active_test = test_name;
    encode_pattern(pat_a, pattern_a_chars, pattern_a_any, pattern_a_len);
    encode_pattern(pat_b, pattern_b_chars, pattern_b_any, pattern_b_len);
    start_ptr = first;
    end_ptr   = last;
    valid     = 1'b1;
    do
        @(negedge clk);
    while (!ready);
    step_cycle();
    valid = 1'b0;
    do
        @(negedge clk);
    while (!done);
    got_accept = accept;
    check_equal(test_name, "error", 0, error);
    jobs_run++;
    // exactly one done per job
    @(negedge clk);
    check_equal(test_name, "done count", jobs_run, done_count);
endtask

task automatic run_text(input string test_name, input int addr, input string text,
                        input string pat_a, input string pat_b, input logic expected);
    logic got;
    load_string(addr, text);
    run_job(test_name, addr, addr + text.len() - 1, pat_a, pat_b, got);
    check_equal(test_name, "accept", expected, got);
endtask

task automatic test_reset_state();
    @(negedge clk);
    check_equal("reset_state", "done", 0, done);
    check_equal("reset_state", "accept", 0, accept);
    check_equal("reset_state", "error", 0, error);
    check_equal("reset_state", "memory_valid", 0, memory_valid);
    stall_mode = STALL_HOLD;
    repeat (2)
        @(negedge clk);
    check_equal("reset_state", "ready under stall", 0, ready);
    stall_mode = STALL_NONE;
    repeat (2)
        @(negedge clk);
    check_equal("reset_state", "ready", 1, ready);
endtask

task automatic test_alternation();
    run_text("alternation_a", 16, "abcd", "abc", "xy", 1'b1);
    run_text("alternation_b", 40, "xyzw", "abc", "xyz", 1'b1);
endtask

task automatic test_rejection();
    run_text("reject_mismatch", 64, "abcabc", "abd", "b", 1'b0);
    run_text("reject_short", 80, "ab", "abc", "abcd", 1'b0);
endtask

task automatic test_dot_symbols();
    run_text("dot_any", 96, "qrst", "q..t", "", 1'b1);
    run_text("dot_other_chars", 112, "qzzt", "q..t", "", 1'b1);
    run_text("dot_literal_mismatch", 128, "qrsu", "q..t", "", 1'b0);
endtask

function automatic string random_text(input int length);
    string s;
    s = "";
    for (int i = 0; i < length; i++)
        s = $sformatf("%s%c", s, 8'h61 + 8'($urandom % 3));
    return s;
endfunction

// symbols lean towards the text so that matches are common
function automatic string random_pattern(input string text);
    string p;
    int    length;
    byte   ch;
    p      = "";
    length = int'($urandom % 5);
    for (int i = 0; i < length; i++)
    begin
        if ($urandom % 4 == 0)
            ch = ".";
        else if (i < text.len() && $urandom % 3 != 0)
            ch = text[i];
        else
            ch = 8'h61 + 8'($urandom % 3);
        p = $sformatf("%s%c", p, ch);
    end
    return p;
endfunction

task automatic test_random_jobs();
    string text;
    string pat_a;
    string pat_b;
    int    addr;
    stall_mode = STALL_RANDOM;
    repeat (20)
    begin
        text  = random_text(1 + int'($urandom % MAX_STR_LEN));
        pat_a = random_pattern(text);
        pat_b = random_pattern(text);
        addr  = 2 * int'($urandom % 2000);
        run_text("random_jobs", addr, text, pat_a, pat_b, model_accept(text, pat_a, pat_b));
    end
    stall_mode = STALL_NONE;
endtask

task automatic test_misaligned_start();
    step_cycle();
    start_ptr = 33;
    end_ptr   = 40;
    valid     = 1'b1;
    step_cycle();
    valid = 1'b0;
    // sticky until reset
    repeat (6)
    begin
        @(negedge clk);
        check_equal("misaligned_start", "error", 1, error);
        check_equal("misaligned_start", "done", 0, done);
    end
    check_equal("misaligned_start", "done count", jobs_run, done_count);
    apply_reset();
    @(negedge clk);
    check_equal("misaligned_start", "error after reset", 0, error);
    run_text("after_reset", 0, "ab", "ab", "", 1'b1);
endtask

// File: bench/tb_regex_coprocessor.sv
// one job in flight at a time; memory stalls come from a fixed seed so every run repeats
`include "regex_macros.svh"

module tb_regex_coprocessor
    import regex_pkg::*;
();
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int MEM_BYTES    = (1 << `REGEX_MEM_ADDR_W) * `REGEX_CHARS_PER_WORD;
    // watchdog budget, in clock periods per job
    localparam int JOB_COUNT    = 30;
    localparam int MAX_STR_LEN  = 8;
    localparam int MAX_STALL    = 40;
    localparam int MARGIN       = 400;
    // memory_ready modes
    localparam int STALL_NONE   = 0;
    localparam int STALL_RANDOM = 1;
    localparam int STALL_HOLD   = 2;

    logic       clk;
    logic       rst;
    logic       valid;
    logic       ready;
    text_ptr_t  start_ptr;
    text_ptr_t  end_ptr;
    pat_chars_t pattern_a_chars;
    pat_any_t   pattern_a_any;
    pat_len_t   pattern_a_len;
    pat_chars_t pattern_b_chars;
    pat_any_t   pattern_b_any;
    pat_len_t   pattern_b_len;
    logic       memory_valid;
    mem_addr_t  memory_addr;
    logic       memory_ready;
    mem_word_t  memory_data = '0;
    logic       done;
    logic       accept;
    logic       error;

    // text memory, one byte per character
    logic [7:0] mem_bytes [MEM_BYTES];
    int         stall_mode  = STALL_NONE;
    int         done_count  = 0;
    int         jobs_run    = 0;
    string      active_test = "reset_state";
    // word the fetcher should ask for next within a job
    mem_addr_t  next_word   = '0;

    regex_coprocessor u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // word shows up on memory_data the cycle after the request is taken
    always @(posedge clk)
    begin
        if (memory_valid && memory_ready)
        begin
            memory_data <= {mem_bytes[{memory_addr, 1'b1}], mem_bytes[{memory_addr, 1'b0}]};
            // a job reads its words in order, starting with the word of start_ptr
            if (valid && ready)
                check_equal(active_test, "first word address",
                            mem_addr_t'(start_ptr / `REGEX_CHARS_PER_WORD), memory_addr);
            else
                check_equal(active_test, "next word address", next_word, memory_addr);
            next_word <= memory_addr + 1'b1;
        end
    end

    // memory back-pressure, changed just after each rising edge
    initial
    begin
        memory_ready = 1'b1;
        forever
        begin
            @(posedge clk);
            #1;
            case (stall_mode)
                STALL_NONE:   memory_ready = 1'b1;
                STALL_RANDOM: memory_ready = ($urandom % 4) != 0;
                default:      memory_ready = 1'b0;
            endcase
        end
    end

    // every done pulse over the whole run
    always @(posedge clk)
    begin
        if (done)
            done_count <= done_count + 1;
    end

    task automatic check_equal(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERROR: %s %s expected %0h actual %0h", test_name, what, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch in %s", test_name);
        end
    endtask

    // inputs change one time unit after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        step_cycle();
        rst = 1'b1;
        repeat (RESET_CYCLES)
            step_cycle();
        rst = 1'b0;
    endtask

    // background bytes mix all address bits so a wrong word is visible
    task automatic fill_memory();
        for (int i = 0; i < MEM_BYTES; i++)
            mem_bytes[i] = 8'(i ^ (i >> 4) ^ (i >> 8));
    endtask

    `include "tb_regex_tests.svh"

    initial
    begin
        void'($urandom(32'hbf33));
        rst             = 1'b1;
        valid           = 1'b0;
        start_ptr       = '0;
        end_ptr         = '0;
        pattern_a_chars = '0;
        pattern_a_any   = '0;
        pattern_a_len   = '0;
        pattern_b_chars = '0;
        pattern_b_any   = '0;
        pattern_b_len   = '0;
        fill_memory();
        apply_reset();
        test_reset_state();
        test_alternation();
        test_rejection();
        test_dot_symbols();
        test_random_jobs();
        test_misaligned_start();
        repeat (4)
            @(negedge clk);
        if (u_dut.u_assertions.failures == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    // worst case per job is a long string read with a long stall
    initial
    begin
        #((JOB_COUNT * (2 * MAX_STR_LEN + MAX_STALL) + MARGIN) * CLK_PERIOD);
        $display("ERROR: watchdog expired, the DUT stopped answering and the run hung");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

// File: bench/regex_assertions.sv
// port-level protocol rules of the coprocessor; all are off while rst is high
module regex_assertions
    import regex_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      done,
    input logic      accept,
    input logic      error,
    input logic      memory_valid,
    input logic      memory_ready,
    input mem_addr_t memory_addr
);
    // failed assertions so far, read by the bench at the end
    int failures = 0;

    // verdict and sticky error exclude each other
    done_not_with_error: assert property (@(posedge clk) disable iff (rst) !(done && error))
        else begin failures++; $error("done and error high together"); end

    // done is a single-cycle pulse
    done_single_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin failures++; $error("done high for more than one cycle"); end

    // stalled request stays put
    request_held: assert property (@(posedge clk) disable iff (rst)
        memory_valid && !memory_ready |=> memory_valid && $stable(memory_addr))
        else begin failures++; $error("memory request dropped or moved under stall"); end

    accept_with_done: assert property (@(posedge clk) disable iff (rst) accept |-> done)
        else begin failures++; $error("accept high without done"); end

endmodule

bind regex_coprocessor regex_assertions u_assertions (
    .clk          (clk),
    .rst          (rst),
    .done         (done),
    .accept       (accept),
    .error        (error),
    .memory_valid (memory_valid),
    .memory_ready (memory_ready),
    .memory_addr  (memory_addr)
);

// File: design/regex_coprocessor.sv
// matches A|B against a prefix of the string; one job at a time, start pointer must be word aligned
module regex_coprocessor
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       valid,
    output logic       ready,
    input  text_ptr_t  start_ptr,
    input  text_ptr_t  end_ptr,
    input  pat_chars_t pattern_a_chars,
    input  pat_any_t   pattern_a_any,
    input  pat_len_t   pattern_a_len,
    input  pat_chars_t pattern_b_chars,
    input  pat_any_t   pattern_b_any,
    input  pat_len_t   pattern_b_len,
    output logic       memory_valid,
    output mem_addr_t  memory_addr,
    input  logic       memory_ready,
    input  mem_word_t  memory_data,
    output logic       done,
    output logic       accept,
    output logic       error
);
    logic  job_start;
    char_t text_char;
    logic  char_valid;
    logic  char_last;
    logic  match_a;
    logic  match_b;
    logic  alive_a;
    logic  alive_b;
    logic  halt;

    // string reader, one character per step
    text_fetcher u_fetch (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .ready        (ready),
        .start_ptr    (start_ptr),
        .end_ptr      (end_ptr),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .halt         (halt),
        .job_start    (job_start),
        .text_char    (text_char),
        .char_valid   (char_valid),
        .char_last    (char_last),
        .error        (error)
    );

    // alternative A
    pattern_lane u_lane_a (
        .clk        (clk),
        .rst        (rst),
        .job_start  (job_start),
        .pat_chars  (pattern_a_chars),
        .pat_any    (pattern_a_any),
        .pat_len    (pattern_a_len),
        .text_char  (text_char),
        .char_valid (char_valid),
        .lane_match (match_a),
        .lane_alive (alive_a)
    );

    // alternative B
    pattern_lane u_lane_b (
        .clk        (clk),
        .rst        (rst),
        .job_start  (job_start),
        .pat_chars  (pattern_b_chars),
        .pat_any    (pattern_b_any),
        .pat_len    (pattern_b_len),
        .text_char  (text_char),
        .char_valid (char_valid),
        .lane_match (match_b),
        .lane_alive (alive_b)
    );

    match_verdict u_verdict (
        .clk        (clk),
        .rst        (rst),
        .job_start  (job_start),
        .char_valid (char_valid),
        .char_last  (char_last),
        .match_a    (match_a),
        .match_b    (match_b),
        .alive_a    (alive_a),
        .alive_b    (alive_b),
        .done       (done),
        .accept     (accept),
        .halt       (halt)
    );

endmodule

// File: design/match_verdict.sv
// decides one cycle after the lane outputs; lane activity after the decision is ignored until job_start
module match_verdict
(
    input  logic clk,
    input  logic rst,
    input  logic job_start,
    input  logic char_valid,
    input  logic char_last,
    input  logic match_a,
    input  logic match_b,
    input  logic alive_a,
    input  logic alive_b,
    output logic done,
    output logic accept,
    output logic halt
);
    // job running and not yet decided
    logic active;
    // a character went into the lanes in the previous cycle
    logic consumed_q;
    // and it was the last one of the string
    logic last_q;
    logic any_match;
    logic all_dead;
    logic decide;

    // alternation A|B
    assign any_match = match_a || match_b;
    assign all_dead  = !alive_a && !alive_b;

    // lane outputs now reflect the character registered in consumed_q
    assign decide = active && consumed_q && (any_match || all_dead || last_q);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active     <= 1'b0;
            consumed_q <= 1'b0;
            last_q     <= 1'b0;
            done       <= 1'b0;
            accept     <= 1'b0;
            halt       <= 1'b0;
        end
        else
        begin
            consumed_q <= char_valid;
            last_q     <= char_valid && char_last;
            // match wins over an ending string
            done       <= decide;
            accept     <= decide && any_match;
            // after the last character the fetcher already went idle and may own a new job
            halt       <= decide && !last_q;
            // a new job may start in the cycle the previous one is decided
            if (job_start)
                active <= 1'b1;
            else if (decide)
                active <= 1'b0;
        end
    end

endmodule

// File: design/pattern_lane.sv
// start-anchored shift-and matcher; pattern is sampled only at job_start, length 0 never matches
`include "regex_macros.svh"

module pattern_lane
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       job_start,
    input  pat_chars_t pat_chars,
    input  pat_any_t   pat_any,
    input  pat_len_t   pat_len,
    input  char_t      text_char,
    input  logic       char_valid,
    output logic       lane_match,
    output logic       lane_alive
);
    pat_chars_t chars_q;
    pat_any_t   any_q;
    pat_len_t   len_q;
    nfa_state_t state_q;
    nfa_state_t hit;
    nfa_state_t len_mask;
    nfa_state_t last_bit;
    nfa_state_t state_next;
    logic       start_live;

    always_comb
    begin
        for (int i = 0; i < `REGEX_PAT_LEN_MAX; i++)
        begin
            // dot takes any character
            hit[i]      = any_q[i] || (chars_q[i*`REGEX_CHAR_W +: `REGEX_CHAR_W] == text_char);
            // symbols past the pattern length stay off
            len_mask[i] = (i < int'(len_q));
            last_bit[i] = ((i + 1) == int'(len_q));
        end
        // anchored, so symbol 0 only starts from the very first character
        state_next[0] = start_live && hit[0];
        for (int i = 1; i < `REGEX_PAT_LEN_MAX; i++)
        begin
            state_next[i] = state_q[i-1] && hit[i];
        end
        state_next = state_next & len_mask;
    end

    // whole pattern seen when the last symbol's bit is set
    assign lane_match = |(state_q & last_bit);
    assign lane_alive = (|state_q) || start_live;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q    <= '0;
            start_live <= 1'b0;
        end
        else if (job_start)
        begin
            state_q    <= '0;
            start_live <= (pat_len != '0);
        end
        else if (char_valid)
        begin
            state_q    <= state_next;
            start_live <= 1'b0;
        end
    end

    // pattern held for the whole job
    always_ff @(posedge clk)
    begin
        if (job_start)
        begin
            chars_q <= pat_chars;
            any_q   <= pat_any;
            len_q   <= pat_len;
        end
    end

endmodule

// File: design/text_fetcher/text_fetcher.sv
// start_ptr must be word aligned (else sticky error until rst); end_ptr is inclusive, >= start_ptr
`include "regex_macros.svh"

module text_fetcher
    import regex_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid,
    output logic      ready,
    input  text_ptr_t start_ptr,
    input  text_ptr_t end_ptr,
    output logic      memory_valid,
    output mem_addr_t memory_addr,
    input  logic      memory_ready,
    input  mem_word_t memory_data,
    input  logic      halt,
    output logic      job_start,
    output char_t     text_char,
    output logic      char_valid,
    output logic      char_last,
    output logic      error
);
    // bits of the pointer that select a character inside a word
    localparam int OFF_W = $clog2(`REGEX_CHARS_PER_WORD);

    fetch_state_t     state;
    fetch_state_t     state_next;
    text_ptr_t        ptr;
    text_ptr_t        ptr_next;
    text_ptr_t        ptr_inc;
    text_ptr_t        end_q;
    mem_word_t        buffer;
    mem_word_t        word_sel;
    logic             drop;
    logic             drop_next;
    logic             aligned;
    logic             job_take;
    logic [OFF_W-1:0] offset;

    assign aligned = (start_ptr[OFF_W-1:0] == '0);
    assign offset  = ptr[OFF_W-1:0];
    assign ptr_inc = ptr + 1'b1;

    // ready needs memory_ready too, so taking the job also takes the first word request
    assign ready    = (state == ST_IDLE) && memory_ready;
    assign job_take = valid && ready && aligned;
    assign job_start = job_take;
    assign error    = (state == ST_ERROR);

    // offset zero means the word was requested in the cycle before and sits on memory_data
    assign word_sel  = (offset == '0) ? memory_data : buffer;
    assign text_char = word_sel[int'(offset) * `REGEX_CHAR_W +: `REGEX_CHAR_W];

    // halt stops delivery in its own cycle
    assign char_valid = (state == ST_STEP) && !halt;
    assign char_last  = char_valid && (ptr == end_q);

    always_comb
    begin
        state_next   = state;
        ptr_next     = ptr;
        drop_next    = drop;
        memory_valid = 1'b0;
        memory_addr  = ptr[OFF_W +: `REGEX_MEM_ADDR_W];
        case (state)
            ST_IDLE:
            begin
                // request the first word only for a job that can be taken
                memory_valid = valid && aligned;
                memory_addr  = start_ptr[OFF_W +: `REGEX_MEM_ADDR_W];
                if (valid && !aligned)
                begin
                    state_next = ST_ERROR;
                end
                else if (job_take)
                begin
                    state_next = ST_STEP;
                    ptr_next   = start_ptr;
                end
            end
            ST_FETCH:
            begin
                // request held until taken, even after halt
                memory_valid = 1'b1;
                if (memory_ready)
                begin
                    state_next = (drop || halt) ? ST_IDLE : ST_STEP;
                    drop_next  = 1'b0;
                end
                else if (halt)
                begin
                    // word still owed by memory, discard it once the request goes through
                    drop_next = 1'b1;
                end
            end
            ST_STEP:
            begin
                if (halt || char_last)
                begin
                    state_next = ST_IDLE;
                end
                else
                begin
                    ptr_next = ptr_inc;
                    // crossing into the next word needs a fresh read
                    if (ptr_inc[OFF_W-1:0] == '0)
                        state_next = ST_FETCH;
                    else
                        state_next = ST_STEP;
                end
            end
            default:
            begin
                // error is left only through rst
                state_next = ST_ERROR;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
            ptr   <= '0;
            drop  <= 1'b0;
        end
        else
        begin
            state <= state_next;
            ptr   <= ptr_next;
            drop  <= drop_next;
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (job_take)
            end_q <= end_ptr;
        // keep the word so the remaining characters come from the buffer
        if ((state == ST_STEP) && (offset == '0))
            buffer <= memory_data;
    end

endmodule

// File: common/regex_pkg.sv
// shared types of the coprocessor; widths come from regex_macros.svh and are not meant to change alone
`include "regex_macros.svh"

package regex_pkg;

    // one text character
    typedef logic [`REGEX_CHAR_W-1:0] char_t;

    // one memory word, character 0 in the low byte
    typedef logic [`REGEX_MEM_W-1:0] mem_word_t;

    // word address towards memory
    typedef logic [`REGEX_MEM_ADDR_W-1:0] mem_addr_t;

    // byte pointer into the string
    typedef logic [`REGEX_PTR_W-1:0] text_ptr_t;

    // pattern characters, symbol 0 in the low byte
    typedef logic [`REGEX_PAT_LEN_MAX*`REGEX_CHAR_W-1:0] pat_chars_t;

    // one flag per symbol, set where the symbol is a dot
    typedef logic [`REGEX_PAT_LEN_MAX-1:0] pat_any_t;

    // number of symbols in use, zero disables the lane
    typedef logic [`REGEX_PAT_LEN_W-1:0] pat_len_t;

    // bit i set while the first i+1 symbols match the text read so far
    typedef logic [`REGEX_PAT_LEN_MAX-1:0] nfa_state_t;

    // fetcher FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_STEP,
        ST_ERROR
    } fetch_state_t;

endpackage

// File: common/regex_macros.svh
// sizes assume two 8-bit characters per 16-bit memory word and patterns of at most four symbols
`ifndef REGEX_MACROS_SVH
`define REGEX_MACROS_SVH

// one text character
`define REGEX_CHAR_W 8

// memory data bus, holds REGEX_CHARS_PER_WORD characters
`define REGEX_MEM_W 16

// word address into the text memory
`define REGEX_MEM_ADDR_W 11

// characters packed into one memory word, low byte first
`define REGEX_CHARS_PER_WORD 2

// byte pointers given by the host
`define REGEX_PTR_W 32

// symbols per pattern lane
`define REGEX_PAT_LEN_MAX 4

// pattern length field, wide enough for 0 up to REGEX_PAT_LEN_MAX
`define REGEX_PAT_LEN_W 3

`endif
